// File: hdl/rp_params.svh
/*
  widths and channel counts for the analog front end
  PDM period and configuration register map
*/

`ifndef RP_PARAMS_SVH
`define RP_PARAMS_SVH

// channel counts
`define RP_ADC_CH 2
`define RP_DAC_CH 2
`define RP_PDM_CH 4

// sample and word widths
`define RP_ADC_DW 16
`define RP_DAC_DW 14
`define RP_GPIO_W 16
`define RP_PDM_DW 8

// pdm period in cycles
`define RP_PDM_RANGE 255

// config bus address width and register map
`define RP_CFG_AW 3
`define RP_REG_LOOP 0
`define RP_REG_IOM 1
`define RP_REG_PDM0 2

`endif

// File: hdl/rp_pkg.sv
/*
  shared data types for the analog front end
  samples, gpio words, pdm values, loop bits, config data
*/

`include "rp_params.svh"

package rp_pkg;

  // signed scope sample, 16 bit converter width
  typedef logic signed [`RP_ADC_DW-1:0] adc_sample_t;

  // signed generator sample as sent to the DAC
  typedef logic signed [`RP_DAC_DW-1:0] dac_sample_t;

  // expansion connector word, n and p rows together
  typedef logic [`RP_GPIO_W-1:0] gpio_t;

  // pdm duty value
  typedef logic [`RP_PDM_DW-1:0] pdm_val_t;

  // one loopback enable per channel
  typedef logic [`RP_DAC_CH-1:0] loop_t;

  // config bus data word
  typedef logic [15:0] cfg_data_t;

endpackage : rp_pkg

// File: hdl/adc_frontend.sv
/*
  ADC capture stage
  input register per channel, then negative slope to two's complement
*/

`include "rp_params.svh"

module adc_frontend (
  input  logic                                     adc_clk,
  input  logic                                     top_rst,
  input  rp_pkg::adc_sample_t [`RP_ADC_CH-1:0]     adc_dat_i,
  output rp_pkg::adc_sample_t [`RP_ADC_CH-1:0]     adc_smp_o
);

  // raw codes straight off the pins
  rp_pkg::adc_sample_t [`RP_ADC_CH-1:0] adc_raw;

  // io registers, lowest 2 bits stay reserved for 16 bit parts
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      adc_raw <= '0;
    end else begin
      adc_raw <= adc_dat_i;
    end
  end

  // sign kept, magnitude bits flipped
  always_comb begin
    for (int i = 0; i < `RP_ADC_CH; i++) begin
      adc_smp_o[i] = {adc_raw[i][`RP_ADC_DW-1], ~adc_raw[i][`RP_ADC_DW-2:0]};
    end
  end

endmodule : adc_frontend

// File: hdl/loop_mux.sv
/*
  generator to scope loopback switch
  per channel source select into the scope path
  DAC strobe gating for channels in loopback
*/

`include "rp_params.svh"

module loop_mux (
  input  logic                                     adc_clk,
  input  logic                                     top_rst,
  input  rp_pkg::loop_t                            loop_i,
  input  rp_pkg::adc_sample_t [`RP_ADC_CH-1:0]     adc_smp_i,
  input  rp_pkg::dac_sample_t [`RP_DAC_CH-1:0]     gen_dat_i,
  input  logic                [`RP_DAC_CH-1:0]     gen_vld_i,
  output logic                [`RP_DAC_CH-1:0]     dac_vld_o,
  output rp_pkg::adc_sample_t [`RP_ADC_CH-1:0]     osc_dat_o
);

  // generator samples widened to scope format
  rp_pkg::adc_sample_t [`RP_ADC_CH-1:0] gen_wide;

  ////////////////////////////////////////
  // 14 bit generator into 16 bit scope
  ////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < `RP_ADC_CH; i++) begin
      // sign extend first, then one bit up
      gen_wide[i] = rp_pkg::adc_sample_t'(gen_dat_i[i]) <<< 1;
    end
  end

  // scope input register, one cycle
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      osc_dat_o <= '0;
    end else begin
      for (int i = 0; i < `RP_ADC_CH; i++) begin
        osc_dat_o[i] <= loop_i[i] ? gen_wide[i] : adc_smp_i[i];
      end
    end
  end

  ////////////////////////////////////////
  // DAC strobe
  ////////////////////////////////////////

  // looped channel freezes its DAC code
  assign dac_vld_o = gen_vld_i & ~loop_i;

endmodule : loop_mux

// File: hdl/dac_backend.sv
/*
  DAC output stage
  per channel holding register with offset code conversion
  two channel interleave onto one bus with select line
*/

`include "rp_params.svh"

module dac_backend (
  input  logic                                     adc_clk,
  input  logic                                     top_rst,
  input  rp_pkg::dac_sample_t [`RP_DAC_CH-1:0]     gen_dat_i,
  input  logic                [`RP_DAC_CH-1:0]     dac_vld_i,
  output logic                [`RP_DAC_DW-1:0]     dac_dat_o,
  output logic                                     dac_sel_o
);

  // mid scale code sits at 0 V on the converter
  localparam logic [`RP_DAC_DW-1:0] dac_mid = `RP_DAC_DW'((1 << (`RP_DAC_DW-1)) - 1);

  // held codes, one per channel
  logic [`RP_DAC_DW-1:0] dac_raw [`RP_DAC_CH];

  // signed to offset binary, negative slope
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      for (int i = 0; i < `RP_DAC_CH; i++) begin
        dac_raw[i] <= dac_mid;
      end
    end else begin
      for (int i = 0; i < `RP_DAC_CH; i++) begin
        if (dac_vld_i[i]) begin
          dac_raw[i] <= {gen_dat_i[i][`RP_DAC_DW-1], ~gen_dat_i[i][`RP_DAC_DW-2:0]};
        end
      end
    end
  end

  ////////////////////////////////////////
  // interleave
  ////////////////////////////////////////

  // select flips each cycle
  // bus carries the channel that sel will mark next
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_sel_o <= 1'b0;
      dac_dat_o <= '0;
    end else begin
      dac_sel_o <= ~dac_sel_o;
      dac_dat_o <= dac_sel_o ? dac_raw[0] : dac_raw[1];
    end
  end

  // converter expects strict alternation
  // first edge out of reset has no toggled predecessor
  a_sel_toggle : assert property (
    @(posedge adc_clk) disable iff (top_rst)
      !$past(top_rst) |-> dac_sel_o != $past(dac_sel_o)
  );

endmodule : dac_backend

// File: hdl/pdm_dac.sv
/*
  pulse density modulator, four channels
  accumulator with fixed 255 cycle period
*/

`include "rp_params.svh"

module pdm_dac (
  input  logic                                     adc_clk,
  input  logic                                     top_rst,
  input  rp_pkg::pdm_val_t    [`RP_PDM_CH-1:0]     pdm_val_i,
  output logic                [`RP_PDM_CH-1:0]     pdm_o
);

  // range at sum width
  localparam logic [`RP_PDM_DW:0] pdm_rng = (`RP_PDM_DW+1)'(`RP_PDM_RANGE);

  // accumulators, always below range
  rp_pkg::pdm_val_t acc_q [`RP_PDM_CH];
  // one extra bit for the carry
  logic [`RP_PDM_DW:0] acc_sum [`RP_PDM_CH];
  logic [`RP_PDM_DW:0] acc_nxt [`RP_PDM_CH];
  logic [`RP_PDM_CH-1:0] acc_hit;

  always_comb begin
    for (int i = 0; i < `RP_PDM_CH; i++) begin
      acc_sum[i] = {1'b0, acc_q[i]} + {1'b0, pdm_val_i[i]};
      acc_hit[i] = acc_sum[i] >= pdm_rng;
      // wrap back by one period on a pulse
      acc_nxt[i] = acc_hit[i] ? acc_sum[i] - pdm_rng : acc_sum[i];
    end
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      for (int i = 0; i < `RP_PDM_CH; i++) begin
        acc_q[i] <= '0;
      end
      pdm_o <= '0;
    end else begin
      for (int i = 0; i < `RP_PDM_CH; i++) begin
        acc_q[i] <= acc_nxt[i][`RP_PDM_DW-1:0];
      end
      pdm_o <= acc_hit;
    end
  end

  // ones per period only exact while the remainder fits
  for (genvar i = 0; i < `RP_PDM_CH; i++) begin : g_acc_chk
    a_acc_range : assert property (
      @(posedge adc_clk) disable iff (top_rst) acc_q[i] < `RP_PDM_RANGE
    );
  end

endmodule : pdm_dac

// File: hdl/gpio_mux.sv
/*
  expansion connector mux
  per bit select between processor GPIO and logic generator
  registered pin drive, two stage input capture
*/

`include "rp_params.svh"

module gpio_mux (
  input  logic          adc_clk,
  input  logic          top_rst,
  input  rp_pkg::gpio_t iom_i,
  input  rp_pkg::gpio_t ps_gpio_o_i,
  input  rp_pkg::gpio_t ps_gpio_oe_i,
  input  rp_pkg::gpio_t lg_dat_i,
  input  rp_pkg::gpio_t lg_oe_i,
  output rp_pkg::gpio_t ps_gpio_i_o,
  input  rp_pkg::gpio_t exp_i,
  output rp_pkg::gpio_t exp_o,
  output rp_pkg::gpio_t exp_oe_o,
  output rp_pkg::gpio_t la_dat_o
);

  // input capture stages
  rp_pkg::gpio_t exp_s1;
  rp_pkg::gpio_t exp_s2;

  // mode bit 0 ps gpio, 1 logic generator
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      exp_o    <= '0;
      exp_oe_o <= '0;
    end else begin
      exp_o    <= (~iom_i & ps_gpio_o_i)  | (iom_i & lg_dat_i);
      exp_oe_o <= (~iom_i & ps_gpio_oe_i) | (iom_i & lg_oe_i);
    end
  end

  // two stage pipelined input capture
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      exp_s1 <= '0;
      exp_s2 <= '0;
    end else begin
      exp_s1 <= exp_i;
      exp_s2 <= exp_s1;
    end
  end

  // same sample to cpu and analyzer
  assign ps_gpio_i_o = exp_s2;
  assign la_dat_o    = exp_s2;

endmodule : gpio_mux

// File: hdl/mgmt_regs.sv
/*
  configuration register bank
  loop bits, gpio mode, pdm values
  write strobe, registered read back
*/

`include "rp_params.svh"

module mgmt_regs (
  input  logic                                     adc_clk,
  input  logic                                     top_rst,
  input  logic                                     cfg_we_i,
  input  logic                [`RP_CFG_AW-1:0]     cfg_addr_i,
  input  rp_pkg::cfg_data_t                        cfg_wdata_i,
  output rp_pkg::cfg_data_t                        cfg_rdata_o,
  output rp_pkg::loop_t                            loop_o,
  output rp_pkg::gpio_t                            iom_o,
  output rp_pkg::pdm_val_t    [`RP_PDM_CH-1:0]     pdm_val_o
);

  // read mux result before the output register
  rp_pkg::cfg_data_t rd_mux;

  ////////////////////////////////////////
  // write side
  ////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      loop_o    <= '0;
      iom_o     <= '0;
      pdm_val_o <= '0;
    end else if (cfg_we_i) begin
      if (cfg_addr_i == `RP_REG_LOOP) begin
        loop_o <= cfg_wdata_i[`RP_DAC_CH-1:0];
      end
      if (cfg_addr_i == `RP_REG_IOM) begin
        iom_o <= cfg_wdata_i[`RP_GPIO_W-1:0];
      end
      // pdm channels at consecutive addresses
      for (int n = 0; n < `RP_PDM_CH; n++) begin
        if (cfg_addr_i == (`RP_REG_PDM0 + n)) begin
          pdm_val_o[n] <= cfg_wdata_i[`RP_PDM_DW-1:0];
        end
      end
    end
  end

  ////////////////////////////////////////
  // read side
  ////////////////////////////////////////

  // unused bits and holes read zero
  always_comb begin
    rd_mux = '0;
    if (cfg_addr_i == `RP_REG_LOOP) begin
      rd_mux = rp_pkg::cfg_data_t'(loop_o);
    end
    if (cfg_addr_i == `RP_REG_IOM) begin
      rd_mux = rp_pkg::cfg_data_t'(iom_o);
    end
    for (int n = 0; n < `RP_PDM_CH; n++) begin
      if (cfg_addr_i == (`RP_REG_PDM0 + n)) begin
        rd_mux = rp_pkg::cfg_data_t'(pdm_val_o[n]);
      end
    end
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      cfg_rdata_o <= '0;
    end else begin
      cfg_rdata_o <= rd_mux;
    end
  end

  // a write to an unknown address would corrupt any register
  a_addr_known : assert property (
    @(posedge adc_clk) disable iff (top_rst) cfg_we_i |-> !$isunknown(cfg_addr_i)
  );

endmodule : mgmt_regs

// File: hdl/rp_analog_top.sv
/*
  analog and digital front end top level
  ADC capture, loopback, DAC interleave, PDM, expansion GPIO
  configuration bank
*/

`include "rp_params.svh"

module rp_analog_top (
  input  logic                                     adc_clk,
  input  logic                                     top_rst,
  // config bus
  input  logic                                     cfg_we_i,
  input  logic                [`RP_CFG_AW-1:0]     cfg_addr_i,
  input  rp_pkg::cfg_data_t                        cfg_wdata_i,
  output rp_pkg::cfg_data_t                        cfg_rdata_o,
  // ADC and scope
  input  rp_pkg::adc_sample_t [`RP_ADC_CH-1:0]     adc_dat_i,
  output rp_pkg::adc_sample_t [`RP_ADC_CH-1:0]     osc_dat_o,
  // generator and DAC
  input  rp_pkg::dac_sample_t [`RP_DAC_CH-1:0]     gen_dat_i,
  input  logic                [`RP_DAC_CH-1:0]     gen_vld_i,
  output logic                [`RP_DAC_DW-1:0]     dac_dat_o,
  output logic                                     dac_sel_o,
  // pdm pins
  output logic                [`RP_PDM_CH-1:0]     pdm_o,
  // expansion connector
  input  rp_pkg::gpio_t                            ps_gpio_o_i,
  input  rp_pkg::gpio_t                            ps_gpio_oe_i,
  output rp_pkg::gpio_t                            ps_gpio_i_o,
  input  rp_pkg::gpio_t                            lg_dat_i,
  input  rp_pkg::gpio_t                            lg_oe_i,
  input  rp_pkg::gpio_t                            exp_i,
  output rp_pkg::gpio_t                            exp_o,
  output rp_pkg::gpio_t                            exp_oe_o,
  output rp_pkg::gpio_t                            la_dat_o
);

  // config outputs
  rp_pkg::loop_t                        cfg_loop;
  rp_pkg::gpio_t                        cfg_iom;
  rp_pkg::pdm_val_t [`RP_PDM_CH-1:0]    cfg_pdm;
  // converted adc samples
  rp_pkg::adc_sample_t [`RP_ADC_CH-1:0] adc_smp;
  // gated generator strobe
  logic [`RP_DAC_CH-1:0]                dac_vld;

  ////////////////////////////////////////
  // management
  ////////////////////////////////////////

  mgmt_regs i_mgmt (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .loop_o      (cfg_loop),
    .iom_o       (cfg_iom),
    .pdm_val_o   (cfg_pdm)
  );

  ////////////////////////////////////////
  // analog paths
  ////////////////////////////////////////

  adc_frontend i_adc (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .adc_smp_o (adc_smp)
  );

  loop_mux i_loop (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .loop_i    (cfg_loop),
    .adc_smp_i (adc_smp),
    .gen_dat_i (gen_dat_i),
    .gen_vld_i (gen_vld_i),
    .dac_vld_o (dac_vld),
    .osc_dat_o (osc_dat_o)
  );

  dac_backend i_dac (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .gen_dat_i (gen_dat_i),
    .dac_vld_i (dac_vld),
    .dac_dat_o (dac_dat_o),
    .dac_sel_o (dac_sel_o)
  );

  pdm_dac i_pdm (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .pdm_val_i (cfg_pdm),
    .pdm_o     (pdm_o)
  );

  ////////////////////////////////////////
  // expansion gpio
  ////////////////////////////////////////

  gpio_mux i_gpio (
    .adc_clk      (adc_clk),
    .top_rst      (top_rst),
    .iom_i        (cfg_iom),
    .ps_gpio_o_i  (ps_gpio_o_i),
    .ps_gpio_oe_i (ps_gpio_oe_i),
    .lg_dat_i     (lg_dat_i),
    .lg_oe_i      (lg_oe_i),
    .ps_gpio_i_o  (ps_gpio_i_o),
    .exp_i        (exp_i),
    .exp_o        (exp_o),
    .exp_oe_o     (exp_oe_o),
    .la_dat_o     (la_dat_o)
  );

endmodule : rp_analog_top

// File: sim/tb_rp_analog_top.sv
/*
  testbench for the analog front end top level
  reference model of config bank, DAC holding regs and pipelines
  comparison process on the falling edge, directed and random tests
*/

`include "rp_params.svh"

module tb_rp_analog_top;

  logic                                 adc_clk;
  logic                                 top_rst;
  logic                                 cfg_we_i;
  logic                [`RP_CFG_AW-1:0] cfg_addr_i;
  rp_pkg::cfg_data_t                    cfg_wdata_i;
  rp_pkg::cfg_data_t                    cfg_rdata_o;
  rp_pkg::adc_sample_t [`RP_ADC_CH-1:0] adc_dat_i;
  rp_pkg::adc_sample_t [`RP_ADC_CH-1:0] osc_dat_o;
  rp_pkg::dac_sample_t [`RP_DAC_CH-1:0] gen_dat_i;
  logic                [`RP_DAC_CH-1:0] gen_vld_i;
  logic                [`RP_DAC_DW-1:0] dac_dat_o;
  logic                                 dac_sel_o;
  logic                [`RP_PDM_CH-1:0] pdm_o;
  rp_pkg::gpio_t                        ps_gpio_o_i;
  rp_pkg::gpio_t                        ps_gpio_oe_i;
  rp_pkg::gpio_t                        ps_gpio_i_o;
  rp_pkg::gpio_t                        lg_dat_i;
  rp_pkg::gpio_t                        lg_oe_i;
  rp_pkg::gpio_t                        exp_i;
  rp_pkg::gpio_t                        exp_o;
  rp_pkg::gpio_t                        exp_oe_o;
  rp_pkg::gpio_t                        la_dat_o;

  // error and activity counters
  int err_cnt = 0;
  int cmp_cycles = 0;
  int pdm_checks = 0;
  logic [31:0] lcg_seed = 32'd13337;

  // model of the config bank
  logic [1:0]  m_loop;
  logic [15:0] m_iom;
  logic [7:0]  m_pdm [`RP_PDM_CH];
  // model of the DAC holding regs now and one edge back
  logic [13:0] hold_cur [`RP_DAC_CH];
  logic [13:0] hold_prev [`RP_DAC_CH];

  // inputs as captured by the last edge (h1) and the one before (h2)
  logic [15:0] adc_h1 [`RP_ADC_CH];
  logic [15:0] adc_h2 [`RP_ADC_CH];
  logic [13:0] gen_h1 [`RP_DAC_CH];
  logic [1:0]  vld_h1;
  logic        we_h1;
  logic [2:0]  addr_h1;
  logic [15:0] wdata_h1;
  logic [15:0] pso_h1, psoe_h1, lgd_h1, lgoe_h1;
  logic [15:0] expi_h1, expi_h2;

  rp_analog_top i_dut (
    .adc_clk      (adc_clk),
    .top_rst      (top_rst),
    .cfg_we_i     (cfg_we_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .cfg_rdata_o  (cfg_rdata_o),
    .adc_dat_i    (adc_dat_i),
    .osc_dat_o    (osc_dat_o),
    .gen_dat_i    (gen_dat_i),
    .gen_vld_i    (gen_vld_i),
    .dac_dat_o    (dac_dat_o),
    .dac_sel_o    (dac_sel_o),
    .pdm_o        (pdm_o),
    .ps_gpio_o_i  (ps_gpio_o_i),
    .ps_gpio_oe_i (ps_gpio_oe_i),
    .ps_gpio_i_o  (ps_gpio_i_o),
    .lg_dat_i     (lg_dat_i),
    .lg_oe_i      (lg_oe_i),
    .exp_i        (exp_i),
    .exp_o        (exp_o),
    .exp_oe_o     (exp_oe_o),
    .la_dat_o     (la_dat_o)
  );

  // 100 unit period
  initial begin
    adc_clk = 1'b0;
    forever #50 adc_clk = ~adc_clk;
  end

  ////////////////////////////////////////
  // reference functions
  ////////////////////////////////////////

  // upper half of the LCG word since low bits repeat too soon
  function automatic logic [15:0] rand16();
    lcg_seed = lcg_seed * 32'd1103515245 + 32'd12345;
    return lcg_seed[31:16];
  endfunction

  // negative slope code counts the magnitude the other way
  function automatic logic [15:0] adc_ref(input logic [15:0] raw);
    return {raw[15], raw[14:0] ^ 15'h7fff};
  endfunction

  // two sign bits on top and a zero at the bottom
  function automatic logic [15:0] loop_ref(input logic [13:0] g);
    return {g[13], g, 1'b0};
  endfunction

  function automatic logic [13:0] dac_ref(input logic [13:0] g);
    return {g[13], g[12:0] ^ 13'h1fff};
  endfunction

  // mode bit set picks the logic generator
  function automatic logic [15:0] gpio_ref(input logic [15:0] mode, input logic [15:0] ps,
                                           input logic [15:0] lg);
    logic [15:0] r;
    for (int i = 0; i < 16; i++) begin
      r[i] = mode[i] ? lg[i] : ps[i];
    end
    return r;
  endfunction

  function automatic logic [15:0] reg_read_ref(input logic [2:0] addr);
    int idx;
    idx = int'(addr) - `RP_REG_PDM0;
    if (addr == `RP_REG_LOOP) begin
      return {14'h0, m_loop};
    end
    if (addr == `RP_REG_IOM) begin
      return m_iom;
    end
    if (idx >= 0 && idx < `RP_PDM_CH) begin
      return {8'h0, m_pdm[idx]};
    end
    return 16'h0;
  endfunction

  task automatic model_write(input logic [2:0] addr, input logic [15:0] d);
    int idx;
    idx = int'(addr) - `RP_REG_PDM0;
    if (addr == `RP_REG_LOOP) begin
      m_loop = d[1:0];
    end
    if (addr == `RP_REG_IOM) begin
      m_iom = d;
    end
    if (idx >= 0 && idx < `RP_PDM_CH) begin
      m_pdm[idx] = d[7:0];
    end
  endtask

  task automatic report_fail(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    err_cnt++;
    $display("[FAIL] %s: expected %0h, actual %0h at %0t", name, exp, act, $time);
  endtask

  ////////////////////////////////////////
  // comparison process
  ////////////////////////////////////////

  // outputs sampled mid cycle while the model steps once per edge
  initial begin : compare_outputs
    logic        rst_edge;
    int          live;
    logic        sel_exp;
    logic [15:0] exp16;
    logic [13:0] exp14;
    live = 0;
    sel_exp = 1'b0;
    forever begin
      @(posedge adc_clk);
      rst_edge = top_rst;
      @(negedge adc_clk);
      if (rst_edge) begin
        live = 0;
        sel_exp = 1'b0;
        m_loop = '0;
        m_iom = '0;
        for (int n = 0; n < `RP_PDM_CH; n++) begin
          m_pdm[n] = '0;
        end
        for (int c = 0; c < `RP_DAC_CH; c++) begin
          hold_cur[c] = 14'h1fff;
          hold_prev[c] = 14'h1fff;
        end
      end else begin
        live++;
        cmp_cycles++;
        // strobes taken at this edge are gated by the loop bits before it
        for (int c = 0; c < `RP_DAC_CH; c++) begin
          hold_prev[c] = hold_cur[c];
          if (vld_h1[c] && !m_loop[c]) begin
            hold_cur[c] = dac_ref(gen_h1[c]);
          end
        end
        sel_exp = ~sel_exp;
        if (dac_sel_o !== sel_exp) begin
          report_fail("dac_sel_o", sel_exp, dac_sel_o);
        end
        exp14 = sel_exp ? hold_prev[1] : hold_prev[0];
        if (dac_dat_o !== exp14) begin
          report_fail("dac_dat_o", exp14, dac_dat_o);
        end
        exp16 = reg_read_ref(addr_h1);
        if (cfg_rdata_o !== exp16) begin
          report_fail("cfg_rdata_o", exp16, cfg_rdata_o);
        end
        exp16 = gpio_ref(m_iom, pso_h1, lgd_h1);
        if (exp_o !== exp16) begin
          report_fail("exp_o", exp16, exp_o);
        end
        exp16 = gpio_ref(m_iom, psoe_h1, lgoe_h1);
        if (exp_oe_o !== exp16) begin
          report_fail("exp_oe_o", exp16, exp_oe_o);
        end
        // two stage paths need two clean edges
        if (live >= 2) begin
          for (int c = 0; c < `RP_ADC_CH; c++) begin
            exp16 = m_loop[c] ? loop_ref(gen_h1[c]) : adc_ref(adc_h2[c]);
            if (osc_dat_o[c] !== exp16) begin
              report_fail($sformatf("osc_dat_o[%0d]", c), exp16, $unsigned(osc_dat_o[c]));
            end
          end
          if (ps_gpio_i_o !== expi_h2) begin
            report_fail("ps_gpio_i_o", expi_h2, ps_gpio_i_o);
          end
          if (la_dat_o !== expi_h2) begin
            report_fail("la_dat_o", expi_h2, la_dat_o);
          end
        end
        // config write lands on this edge
        if (we_h1) begin
          model_write(addr_h1, wdata_h1);
        end
      end
      // shift input history
      adc_h2 = adc_h1;
      expi_h2 = expi_h1;
      for (int c = 0; c < `RP_ADC_CH; c++) begin
        adc_h1[c] = adc_dat_i[c];
        gen_h1[c] = gen_dat_i[c];
      end
      vld_h1 = gen_vld_i;
      we_h1 = cfg_we_i;
      addr_h1 = cfg_addr_i;
      wdata_h1 = cfg_wdata_i;
      pso_h1 = ps_gpio_o_i;
      psoe_h1 = ps_gpio_oe_i;
      lgd_h1 = lg_dat_i;
      lgoe_h1 = lg_oe_i;
      expi_h1 = exp_i;
    end
  end

  ////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////

  // inputs change shortly after the rising edge
  task automatic step_cycle();
    @(posedge adc_clk);
    #10;
  endtask

  task automatic write_reg(input logic [2:0] addr, input logic [15:0] data);
    cfg_we_i = 1'b1;
    cfg_addr_i = addr;
    cfg_wdata_i = data;
    step_cycle();
    cfg_we_i = 1'b0;
  endtask

  // read data shows up one cycle after the address
  task automatic read_reg(input logic [2:0] addr);
    cfg_addr_i = addr;
    step_cycle();
    step_cycle();
  endtask

  task automatic drive_random(input logic [1:0] vld_mask);
    logic [15:0] r;
    for (int c = 0; c < `RP_ADC_CH; c++) begin
      adc_dat_i[c] = rand16();
      r = rand16();
      gen_dat_i[c] = r[13:0];
    end
    r = rand16();
    gen_vld_i = r[1:0] & vld_mask;
    ps_gpio_o_i = rand16();
    ps_gpio_oe_i = rand16();
    lg_dat_i = rand16();
    lg_oe_i = rand16();
    exp_i = rand16();
    step_cycle();
  endtask

  // mid scale code must show right after reset
  task automatic wait_dac_mid(output logic ok);
    ok = 1'b0;
    for (int i = 0; i < 8 && !ok; i++) begin
      @(negedge adc_clk);
      if (dac_dat_o == 14'h1fff) begin
        ok = 1'b1;
      end
    end
    step_cycle();
  endtask

  // one settling period, then count ones over one period
  task automatic run_pdm(input logic [7:0] v0, input logic [7:0] v1,
                         input logic [7:0] v2, input logic [7:0] v3);
    logic [7:0] val [`RP_PDM_CH];
    int         cnt [`RP_PDM_CH];
    val[0] = v0;
    val[1] = v1;
    val[2] = v2;
    val[3] = v3;
    for (int n = 0; n < `RP_PDM_CH; n++) begin
      write_reg(3'(`RP_REG_PDM0 + n), {8'hc3, val[n]});
      cnt[n] = 0;
    end
    repeat (`RP_PDM_RANGE) step_cycle();
    repeat (`RP_PDM_RANGE) begin
      @(negedge adc_clk);
      for (int n = 0; n < `RP_PDM_CH; n++) begin
        cnt[n] += pdm_o[n];
      end
    end
    for (int n = 0; n < `RP_PDM_CH; n++) begin
      pdm_checks++;
      if (cnt[n] != val[n]) begin
        report_fail($sformatf("pdm_o[%0d] ones", n), val[n], cnt[n]);
      end
    end
    step_cycle();
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin : run_tests
    logic        ok;
    logic [15:0] r;
    top_rst = 1'b1;
    cfg_we_i = 1'b0;
    cfg_addr_i = '0;
    cfg_wdata_i = '0;
    adc_dat_i = '0;
    gen_dat_i = '0;
    gen_vld_i = '0;
    ps_gpio_o_i = '0;
    ps_gpio_oe_i = '0;
    lg_dat_i = '0;
    lg_oe_i = '0;
    exp_i = '0;
    repeat (4) @(posedge adc_clk);
    #10;
    top_rst = 1'b0;
    wait_dac_mid(ok);
    if (ok) begin
      // config bank with unused bits and holes
      write_reg(`RP_REG_LOOP, 16'hffff);
      write_reg(`RP_REG_IOM, 16'ha5c3);
      for (int n = 0; n < `RP_PDM_CH; n++) begin
        write_reg(3'(`RP_REG_PDM0 + n), 16'h5a00 | 16'(8'h11 * (n + 1)));
      end
      write_reg(3'd6, 16'hffff);
      write_reg(3'd7, 16'hffff);
      for (int a = 0; a < 8; a++) begin
        read_reg(3'(a));
      end
      write_reg(`RP_REG_IOM, 16'h0);
      // ADC path, no loopback
      write_reg(`RP_REG_LOOP, 16'h0);
      repeat (40) drive_random(2'b00);
      // loopback per channel with the looped DAC code frozen
      for (int m = 1; m < 4; m++) begin
        write_reg(`RP_REG_LOOP, 16'(m));
        repeat (30) drive_random(2'b11);
      end
      // DAC interleave with random strobes
      write_reg(`RP_REG_LOOP, 16'h0);
      repeat (40) drive_random(2'b11);
      // PDM with both ends of the range
      gen_vld_i = '0;
      run_pdm(8'd0, 8'd255, 8'd1, 8'd128);
      r = rand16();
      run_pdm(8'd254, r[7:0], 8'd17, 8'd255);
      // expansion mux with random and full modes
      write_reg(`RP_REG_IOM, rand16());
      repeat (30) drive_random(2'b00);
      write_reg(`RP_REG_IOM, 16'hffff);
      repeat (20) drive_random(2'b00);
      write_reg(`RP_REG_IOM, rand16());
      repeat (30) drive_random(2'b00);
    end else begin
      $display("timeout: dac_dat_o never showed the mid-scale code after reset");
      err_cnt++;
    end
    step_cycle();
    step_cycle();
    $display("compared cycles: %0d, pdm checks: %0d, errors: %0d",
             cmp_cycles, pdm_checks, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule : tb_rp_analog_top

// File: verilog.f
+incdir+hdl
hdl/rp_pkg.sv
hdl/adc_frontend.sv
hdl/loop_mux.sv
hdl/dac_backend.sv
hdl/pdm_dac.sv
hdl/gpio_mux.sv
hdl/mgmt_regs.sv
hdl/rp_analog_top.sv
sim/tb_rp_analog_top.sv
